//--- source/alu_pkg.sv
//--------------------------------------------------
// ALU package: opcodes, data word, register tag
// and handshake state types
//--------------------------------------------------
package alu_pkg;

    // 64-bit data word for operands and results
    typedef logic [63:0] word_t;

    // Architectural destination register index
    typedef logic [4:0] reg_tag_t;

    //--------------------------------------------------
    // ALU opcodes
    //--------------------------------------------------
    // NOP must stay last, the core checks op range against it
    typedef enum logic [5:0] {
        // Add and subtract
        ADD,
        SUB,
        ADDW,
        SUBW,
        // Zba address generation
        ADDUW,
        SH1ADD,
        SH2ADD,
        SH3ADD,
        SH1ADDUW,
        SH2ADDUW,
        SH3ADDUW,
        // Shifts
        SLL,
        SRL,
        SRA,
        SLLW,
        SRLW,
        SRAW,
        SLLIUW,
        // Rotates
        ROR,
        ROL,
        RORW,
        ROLW,
        // Compare, min and max
        SLT,
        SLTU,
        MIN,
        MINU,
        MAX,
        MAXU,
        // Bitwise logic
        AND_OP,
        OR_OP,
        XOR_OP,
        XNOR_OP,
        ORN,
        ANDN,
        ORCB,
        // Extension and byte reverse
        ZEXTW, ZEXTH, SEXTH, SEXTB, REV8,
        NOP
    } alu_op_e;

    // Request stage FSM
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } hs_state_e;

endpackage

//--- source/alu_unit_if.sv
//--------------------------------------------------
// Operand, opcode and result bundle between the
// ALU core and one of its sub-units
//--------------------------------------------------
`timescale 1ns/100ps

interface alu_unit_if;
    import alu_pkg::*;

    word_t   data_rs1;
    word_t   data_rs2;
    alu_op_e op;
    word_t   result;

    // Core side
    modport core (
        output data_rs1,
        output data_rs2,
        output op,
        input  result
    );

    // Sub-unit side
    modport unit (
        input  data_rs1,
        input  data_rs2,
        input  op,
        output result
    );

endinterface

//--- source/alu_add.sv
//--------------------------------------------------
// ALU adder: add, sub, W forms and shNadd forms
//--------------------------------------------------
`timescale 1ns/100ps

module alu_add (
    alu_unit_if.unit unit_if
);
    import alu_pkg::*;

    logic  is_sub;
    word_t operand_b;
    word_t sum;

    // Only SUB and SUBW take the difference
    always_comb begin
        case (unit_if.op)
            SUB, SUBW: begin
                is_sub = 1'b1;
            end
            default: begin
                is_sub = 1'b0;
            end
        endcase
    end

    // Single adder, two's complement on rs2 for subtraction
    assign operand_b = unit_if.data_rs2 ^ {64{is_sub}};
    assign sum       = unit_if.data_rs1 + operand_b + word_t'(is_sub);

    // rs1 comes in already extended and pre-shifted by the core
    always_comb begin
        case (unit_if.op)
            ADD, SUB, ADDW, SUBW,
            ADDUW, SH1ADD, SH2ADD, SH3ADD,
            SH1ADDUW, SH2ADDUW, SH3ADDUW: begin
                unit_if.result = sum;
            end
            default: begin
                unit_if.result = '0;
            end
        endcase
    end

endmodule

//--- source/alu_shift.sv
//--------------------------------------------------
// ALU shifter: logical and arithmetic shifts and
// rotates, 64-bit and 32-bit forms
//--------------------------------------------------
`timescale 1ns/100ps

module alu_shift (
    alu_unit_if.unit unit_if
);
    import alu_pkg::*;

    word_t       rs1;
    logic [5:0]  amt;
    logic [5:0]  amt_neg;
    logic [31:0] word;
    logic [4:0]  amt_w;
    logic [4:0]  amt_w_neg;

    // rs1 is already zero or sign extended for the W forms
    assign rs1  = unit_if.data_rs1;
    assign word = unit_if.data_rs1[31:0];

    // 6-bit amount for 64-bit forms, 5-bit for W forms
    assign amt       = unit_if.data_rs2[5:0];
    assign amt_w     = unit_if.data_rs2[4:0];
    assign amt_neg   = 6'd0 - amt;
    assign amt_w_neg = 5'd0 - amt_w;

    always_comb begin
        case (unit_if.op)
            SLL, SLLIUW: begin
                unit_if.result = rs1 << amt;
            end
            SLLW: begin
                unit_if.result = rs1 << amt_w;
            end
            SRL: begin
                unit_if.result = rs1 >> amt;
            end
            SRLW: begin
                unit_if.result = rs1 >> amt_w;
            end
            SRA: begin
                unit_if.result = word_t'($signed(rs1) >>> amt);
            end
            SRAW: begin
                unit_if.result = word_t'($signed(rs1) >>> amt_w);
            end
            // Rotates as two opposing shifts, amount 0 leaves rs1
            ROR: begin
                unit_if.result = (rs1 >> amt) | (rs1 << amt_neg);
            end
            ROL: begin
                unit_if.result = (rs1 << amt) | (rs1 >> amt_neg);
            end
            RORW: begin
                unit_if.result = {32'b0, (word >> amt_w) | (word << amt_w_neg)};
            end
            ROLW: begin
                unit_if.result = {32'b0, (word << amt_w) | (word >> amt_w_neg)};
            end
            default: begin
                unit_if.result = '0;
            end
        endcase
    end

endmodule

//--- source/alu_cmp.sv
//--------------------------------------------------
// ALU compare unit: set-less-than, min and max
//--------------------------------------------------
`timescale 1ns/100ps

module alu_cmp (
    alu_unit_if.unit unit_if
);
    import alu_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(unit_if.data_rs1) < $signed(unit_if.data_rs2);
    assign lt_unsigned = unit_if.data_rs1 < unit_if.data_rs2;

    always_comb begin
        case (unit_if.op)
            SLT: begin
                unit_if.result = {63'b0, lt_signed};
            end
            SLTU: begin
                unit_if.result = {63'b0, lt_unsigned};
            end
            // Min and max return one of the operands unchanged
            MIN: begin
                unit_if.result = lt_signed ? unit_if.data_rs1 : unit_if.data_rs2;
            end
            MINU: begin
                unit_if.result = lt_unsigned ? unit_if.data_rs1 : unit_if.data_rs2;
            end
            MAX: begin
                unit_if.result = lt_signed ? unit_if.data_rs2 : unit_if.data_rs1;
            end
            MAXU: begin
                unit_if.result = lt_unsigned ? unit_if.data_rs2 : unit_if.data_rs1;
            end
            default: begin
                unit_if.result = '0;
            end
        endcase
    end

endmodule

//--- source/alu_logic.sv
//--------------------------------------------------
// ALU logic unit: bitwise ops and orc.b
//--------------------------------------------------
`timescale 1ns/100ps

module alu_logic (
    alu_unit_if.unit unit_if
);
    import alu_pkg::*;

    word_t rs2_eff;
    word_t orc_b;

    // orn and andn work on the inverted rs2
    assign rs2_eff = (unit_if.op inside {ORN, ANDN}) ? ~unit_if.data_rs2
                                                     : unit_if.data_rs2;

    // Each byte saturates to all ones when any bit is set
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            orc_b[8*b +: 8] = {8{|unit_if.data_rs1[8*b +: 8]}};
        end
    end

    always_comb begin
        case (unit_if.op)
            AND_OP, ANDN: begin
                unit_if.result = unit_if.data_rs1 & rs2_eff;
            end
            OR_OP, ORN: begin
                unit_if.result = unit_if.data_rs1 | rs2_eff;
            end
            XOR_OP: begin
                unit_if.result = unit_if.data_rs1 ^ rs2_eff;
            end
            XNOR_OP: begin
                unit_if.result = ~(unit_if.data_rs1 ^ rs2_eff);
            end
            ORCB: begin
                unit_if.result = orc_b;
            end
            default: begin
                unit_if.result = '0;
            end
        endcase
    end

endmodule

//--- source/alu.sv
//--------------------------------------------------
// Combinational RV64 integer ALU core with Zba and
// Zbb, built from four sub-units
//--------------------------------------------------
`timescale 1ns/100ps

module alu (
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::word_t   rs1_i,
    input  alu_pkg::word_t   rs2_i,
    output alu_pkg::word_t   result_o
);
    import alu_pkg::*;

    word_t rs1_ext;
    word_t rs1_shifted;
    word_t unit_result;
    word_t rev_bytes;

    //--------------------------------------------------
    // Operand preparation
    //--------------------------------------------------
    always_comb begin
        case (op_i)
            ADDUW, SH1ADDUW, SH2ADDUW, SH3ADDUW, ZEXTW,
            SLLIUW, SLLW, SRLW, RORW, ROLW: begin
                rs1_ext = {32'b0, rs1_i[31:0]};
            end
            ZEXTH: rs1_ext = {48'b0, rs1_i[15:0]};
            SRAW:  rs1_ext = {{32{rs1_i[31]}}, rs1_i[31:0]};
            SEXTH: rs1_ext = {{48{rs1_i[15]}}, rs1_i[15:0]};
            SEXTB: rs1_ext = {{56{rs1_i[7]}}, rs1_i[7:0]};
            default: rs1_ext = rs1_i;
        endcase
    end

    // Scaled index for shNadd
    always_comb begin
        case (op_i)
            SH1ADD, SH1ADDUW: rs1_shifted = rs1_ext << 1;
            SH2ADD, SH2ADDUW: rs1_shifted = rs1_ext << 2;
            SH3ADD, SH3ADDUW: rs1_shifted = rs1_ext << 3;
            default:          rs1_shifted = rs1_ext;
        endcase
    end

    //--------------------------------------------------
    // Sub-units
    //--------------------------------------------------
    alu_unit_if add_if ();
    alu_unit_if shift_if ();
    alu_unit_if cmp_if ();
    alu_unit_if logic_if ();

    assign add_if.data_rs1   = rs1_shifted;
    assign shift_if.data_rs1 = rs1_ext;
    assign cmp_if.data_rs1   = rs1_i;
    assign logic_if.data_rs1 = rs1_i;

    assign add_if.data_rs2   = rs2_i;
    assign shift_if.data_rs2 = rs2_i;
    assign cmp_if.data_rs2   = rs2_i;
    assign logic_if.data_rs2 = rs2_i;

    assign add_if.op   = op_i;
    assign shift_if.op = op_i;
    assign cmp_if.op   = op_i;
    assign logic_if.op = op_i;

    alu_add   alu_add_inst   (.unit_if(add_if.unit));
    alu_shift alu_shift_inst (.unit_if(shift_if.unit));
    alu_cmp   alu_cmp_inst   (.unit_if(cmp_if.unit));
    alu_logic alu_logic_inst (.unit_if(logic_if.unit));

    // Pick the unit by opcode class
    always_comb begin
        case (op_i)
            ADD, SUB, ADDW, SUBW, ADDUW, SH1ADD, SH2ADD, SH3ADD,
            SH1ADDUW, SH2ADDUW, SH3ADDUW: unit_result = add_if.result;
            SLL, SRL, SRA, SLLW, SRLW, SRAW, SLLIUW,
            ROR, ROL, RORW, ROLW:         unit_result = shift_if.result;
            SLT, SLTU, MIN, MINU, MAX, MAXU: unit_result = cmp_if.result;
            AND_OP, OR_OP, XOR_OP, XNOR_OP,
            ORN, ANDN, ORCB:              unit_result = logic_if.result;
            default:                      unit_result = '0;
        endcase
    end

    //--------------------------------------------------
    // Result
    //--------------------------------------------------
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            rev_bytes[8*b +: 8] = rs1_i[56-8*b +: 8];
        end
    end

    always_comb begin
        case (op_i)
            ADDW, SUBW, SLLW, SRLW, SRAW, RORW, ROLW: begin
                result_o = {{32{unit_result[31]}}, unit_result[31:0]};
            end
            ZEXTW, ZEXTH, SEXTH, SEXTB: result_o = rs1_ext;
            REV8:                       result_o = rev_bytes;
            default:                    result_o = unit_result;
        endcase
    end

    // Catch encodings past the end of the opcode list
    always_comb begin
        if (!$isunknown(op_i)) begin
            assert (op_i <= NOP)
                else $error("ALU got an undefined opcode %0d", op_i);
        end
    end

endmodule

//--- source/exe_alu_handshake.sv
//--------------------------------------------------
// ALU request stage: four-phase req/ack, latches
// the request and holds the registered result
//--------------------------------------------------
`timescale 1ns/100ps

module exe_alu_handshake (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              req_i,
    input  alu_pkg::alu_op_e  op_i,
    input  alu_pkg::word_t    rs1_i,
    input  alu_pkg::word_t    rs2_i,
    input  alu_pkg::reg_tag_t rd_i,
    input  alu_pkg::word_t    alu_result_i,
    output logic              ack_o,
    output alu_pkg::word_t    result_o,
    output alu_pkg::reg_tag_t rd_o,
    output alu_pkg::alu_op_e  alu_op_o,
    output alu_pkg::word_t    alu_rs1_o,
    output alu_pkg::word_t    alu_rs2_o
);
    import alu_pkg::*;

    hs_state_e state_q;
    logic      accept;
    alu_op_e   op_q;
    word_t     rs1_q;
    word_t     rs2_q;
    reg_tag_t  rd_q;

    assign accept = (state_q == IDLE) && req_i;

    // Request payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rs1_q <= rs1_i;
            rs2_q <= rs2_i;
            rd_q  <= rd_i;
        end
    end

    //--------------------------------------------------
    // FSM
    //--------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= IDLE;
            op_q     <= NOP;
            ack_o    <= 1'b0;
            result_o <= '0;
            rd_o     <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_i) begin
                        op_q    <= op_i;
                        state_q <= BUSY;
                    end
                end
                // ALU settles in one cycle on the latched operands
                BUSY: begin
                    result_o <= alu_result_i;
                    rd_o     <= rd_q;
                    ack_o    <= 1'b1;
                    state_q  <= DONE;
                end
                // Hold until the requester lets go
                DONE: begin
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign alu_op_o  = op_q;
    assign alu_rs1_o = rs1_q;
    assign alu_rs2_o = rs2_q;

    // Protocol checks
    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(ack_o) |-> $past(req_i))
        else $error("ack_o rose with no request pending in state %s", state_q.name());

    a_result_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ack_o && $past(ack_o)) |-> ($stable(result_o) && $stable(rd_o)))
        else $error("result changed while ack_o was high");

    a_ack_falls_late: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(ack_o) |-> !$past(req_i))
        else $error("ack_o dropped while req_i was still high");

endmodule

//--- source/exe_alu_top.sv
//--------------------------------------------------
// ALU execution stage top: request stage around
// the combinational ALU core
//--------------------------------------------------
`timescale 1ns/100ps

module exe_alu_top (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              req_i,
    input  alu_pkg::alu_op_e  op_i,
    input  alu_pkg::word_t    rs1_i,
    input  alu_pkg::word_t    rs2_i,
    input  alu_pkg::reg_tag_t rd_i,
    output logic              ack_o,
    output alu_pkg::word_t    result_o,
    output alu_pkg::reg_tag_t rd_o
);
    import alu_pkg::*;

    // Latched operation toward the ALU and its result back
    alu_op_e alu_op;
    word_t   alu_rs1;
    word_t   alu_rs2;
    word_t   alu_result;

    exe_alu_handshake exe_alu_handshake_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .op_i        (op_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .rd_i        (rd_i),
        .alu_result_i(alu_result),
        .ack_o       (ack_o),
        .result_o    (result_o),
        .rd_o        (rd_o),
        .alu_op_o    (alu_op),
        .alu_rs1_o   (alu_rs1),
        .alu_rs2_o   (alu_rs2)
    );

    alu alu_inst (
        .op_i    (alu_op),
        .rs1_i   (alu_rs1),
        .rs2_i   (alu_rs2),
        .result_o(alu_result)
    );

endmodule

//--- sim/tb_clock_gen.sv
//--------------------------------------------------
// Testbench clock and reset generator
//--------------------------------------------------
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // Reset held low for 8 cycles
    initial begin
        arst_n_o = 1'b0;
        repeat (8) @(negedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

//--- sim/tb_exe_alu_checker.sv
//--------------------------------------------------
// Result monitor for the ALU stage: compares result,
// tag, ack latency and hold behavior
//--------------------------------------------------
`timescale 1ns/100ps

module tb_exe_alu_checker (
    input logic              clk_i,
    input logic              arst_n_i,
    input logic              req_i,
    input logic              ack_i,
    input alu_pkg::word_t    result_i,
    input alu_pkg::reg_tag_t rd_i
);
    import alu_pkg::*;

    localparam int ack_latency = 2;

    string    exp_name;
    word_t    exp_result;
    reg_tag_t exp_rd;
    logic     exp_valid = 1'b0;
    word_t    held_result;
    reg_tag_t held_rd;
    logic     req_q = 1'b0;
    logic     ack_q = 1'b0;
    int       latency = 0;
    int       mismatch_count = 0;
    int       protocol_count = 0;

    // Loaded by the driver before each request
    task automatic expect_result(input string name, input word_t result, input reg_tag_t rd);
        exp_name   = name;
        exp_result = result;
        exp_rd     = rd;
        exp_valid  = 1'b1;
    endtask

    // Outputs must come out of reset cleared
    always @(posedge arst_n_i) begin
        if (ack_i !== 1'b0) begin
            $display("Mismatch reset ack_o: expected 0, actual %0b", ack_i);
            mismatch_count++;
        end
        if (result_i !== '0) begin
            $display("Mismatch reset result_o: expected 0x%016h, actual 0x%016h", 64'h0, result_i);
            mismatch_count++;
        end
        if (rd_i !== '0) begin
            $display("Mismatch reset rd_o: expected 0, actual %0d", rd_i);
            mismatch_count++;
        end
    end

    //--------------------------------------------------
    // Sampling at the falling edge, away from updates
    //--------------------------------------------------
    always @(negedge clk_i) begin
        if (!arst_n_i) begin
            req_q = 1'b0;
            ack_q = 1'b0;
        end else begin
            // Cycles since the request was first seen
            if (req_i && !req_q) begin
                latency = 0;
            end else if (req_i && !ack_q) begin
                latency++;
            end

            if (ack_i && !ack_q) begin
                if (!exp_valid) begin
                    $display("ack_o rose although no request was pending");
                    protocol_count++;
                end else begin
                    if (result_i !== exp_result) begin
                        $display("Mismatch %s result: expected 0x%016h, actual 0x%016h",
                                 exp_name, exp_result, result_i);
                        mismatch_count++;
                    end
                    if (rd_i !== exp_rd) begin
                        $display("Mismatch %s rd_o: expected %0d, actual %0d",
                                 exp_name, exp_rd, rd_i);
                        mismatch_count++;
                    end
                    if (latency != ack_latency) begin
                        $display("Mismatch %s ack latency: expected %0d, actual %0d",
                                 exp_name, ack_latency, latency);
                        mismatch_count++;
                    end
                end
                exp_valid   = 1'b0;
                held_result = result_i;
                held_rd     = rd_i;
            end else if (ack_i && ack_q) begin
                // Result and tag frozen during back-pressure
                if (result_i !== held_result) begin
                    $display("Mismatch %s held result: expected 0x%016h, actual 0x%016h",
                             exp_name, held_result, result_i);
                    mismatch_count++;
                end
                if (rd_i !== held_rd) begin
                    $display("Mismatch %s held rd_o: expected %0d, actual %0d",
                             exp_name, held_rd, rd_i);
                    mismatch_count++;
                end
            end else if (!ack_i && ack_q && req_q) begin
                $display("ack_o dropped in test %s while req_i was still high", exp_name);
                protocol_count++;
            end

            req_q = req_i;
            ack_q = ack_i;
        end
    end

endmodule

//--- sim/tb_exe_alu.sv
//--------------------------------------------------
// Testbench top for the ALU execution stage
//--------------------------------------------------
`timescale 1ns/100ps

module tb_exe_alu;
    import alu_pkg::*;

    localparam int ack_timeout = 20;

    logic     clk;
    logic     arst_n;
    logic     req;
    alu_op_e  op;
    word_t    rs1;
    word_t    rs2;
    reg_tag_t rd;
    logic     ack;
    word_t    result;
    reg_tag_t rd_out;

    // Stimulus table, one slot per test
    string    names[$];
    alu_op_e  ops[$];
    word_t    rs1_tbl[$];
    word_t    rs2_tbl[$];
    word_t    exp_tbl[$];
    reg_tag_t rd_tbl[$];
    int       hold_tbl[$];
    int       timeout_count = 0;

    tb_clock_gen clock_gen_inst (
        .clk_o   (clk),
        .arst_n_o(arst_n)
    );

    exe_alu_top exe_alu_top_inst (
        .clk_i   (clk),
        .arst_n_i(arst_n),
        .req_i   (req),
        .op_i    (op),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .rd_i    (rd),
        .ack_o   (ack),
        .result_o(result),
        .rd_o    (rd_out)
    );

    tb_exe_alu_checker checker_inst (
        .clk_i   (clk),
        .arst_n_i(arst_n),
        .req_i   (req),
        .ack_i   (ack),
        .result_i(result),
        .rd_i    (rd_out)
    );

    // Random destination tag per entry
    task automatic add_vector(input string name, input alu_op_e op_v, input word_t a,
                              input word_t b, input word_t exp, input int hold);
        names.push_back(name);
        ops.push_back(op_v);
        rs1_tbl.push_back(a);
        rs2_tbl.push_back(b);
        exp_tbl.push_back(exp);
        rd_tbl.push_back(reg_tag_t'($urandom));
        hold_tbl.push_back(hold);
    endtask

    // Four-phase request with optional back-pressure
    task automatic run_vector(input int idx);
        int cycles;
        checker_inst.expect_result(names[idx], exp_tbl[idx], rd_tbl[idx]);
        @(posedge clk);
        op  <= ops[idx];
        rs1 <= rs1_tbl[idx];
        rs2 <= rs2_tbl[idx];
        rd  <= rd_tbl[idx];
        req <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!ack && cycles < ack_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!ack) begin
            $display("Timeout in test %s: ack_o never rose", names[idx]);
            timeout_count++;
        end
        repeat (hold_tbl[idx]) @(posedge clk);
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (ack && cycles < ack_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (ack) begin
            $display("Timeout in test %s: ack_o never fell", names[idx]);
            timeout_count++;
        end
    endtask

    initial begin
        int cycles;
        int errors;
        req <= 1'b0;
        op  <= NOP;
        rs1 <= '0;
        rs2 <= '0;
        rd  <= '0;
        void'($urandom(58740));

        //--------------------------------------------------
        // Adds and shifted adds
        //--------------------------------------------------
        add_vector("add_wrap", ADD, 64'hFFFF_FFFF_FFFF_FFFF, 64'h2, 64'h1, 0);
        add_vector("sub_wrap", SUB, 64'h0, 64'h1, 64'hFFFF_FFFF_FFFF_FFFF, 0);
        add_vector("addw_ovf", ADDW, 64'h7FFF_FFFF, 64'h1, 64'hFFFF_FFFF_8000_0000, 0);
        add_vector("subw_low", SUBW, 64'h1_0000_0000, 64'h1, 64'hFFFF_FFFF_FFFF_FFFF, 0);
        add_vector("adduw", ADDUW, 64'hFFFF_FFFF_8000_0000, 64'h1, 64'h8000_0001, 0);
        add_vector("sh1add", SH1ADD, 64'h8000_0000_0000_0001, 64'h0, 64'h2, 0);
        add_vector("sh3add", SH3ADD, 64'h10, 64'h5, 64'h85, 0);
        add_vector("sh2adduw", SH2ADDUW, 64'hFFFF_FFFF_0000_0003, 64'h1000, 64'h100C, 0);
        // Shifts and rotates
        add_vector("sra_neg", SRA, 64'h8000_0000_0000_0000, 64'h4, 64'hF800_0000_0000_0000, 0);
        add_vector("srl", SRL, 64'h8000_0000_0000_0000, 64'h4, 64'h0800_0000_0000_0000, 0);
        add_vector("sll_6bit", SLL, 64'h1, 64'h43, 64'h8, 0);
        add_vector("srlw_5bit", SRLW, 64'hFFFF_FFFF_8000_0000, 64'h20, 64'hFFFF_FFFF_8000_0000, 0);
        add_vector("srlw_pos", SRLW, 64'h8000_0000, 64'h21, 64'h4000_0000, 0);
        add_vector("sraw", SRAW, 64'h8000_0000, 64'h4, 64'hFFFF_FFFF_F800_0000, 0);
        add_vector("sllw", SLLW, 64'h1, 64'h1F, 64'hFFFF_FFFF_8000_0000, 0);
        add_vector("slliuw", SLLIUW, 64'hFFFF_FFFF_8000_0001, 64'h4, 64'h8_0000_0010, 0);
        add_vector("rol_4", ROL, 64'hA123_4567_89AB_CDEF, 64'h4, 64'h1234_5678_9ABC_DEFA, 0);
        add_vector("ror_8", ROR, 64'h0123_4567_89AB_CDEF, 64'h8, 64'hEF01_2345_6789_ABCD, 0);
        add_vector("rorw", RORW, 64'hFFFF_FFFF_0000_0001, 64'h1, 64'hFFFF_FFFF_8000_0000, 0);
        add_vector("rolw", ROLW, 64'h8000_0000, 64'h1, 64'h1, 0);
        // Compares, min and max on -1 and 1
        add_vector("slt", SLT, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 64'h1, 0);
        add_vector("sltu", SLTU, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 64'h0, 0);
        add_vector("min", MIN, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 64'hFFFF_FFFF_FFFF_FFFF, 0);
        add_vector("minu", MINU, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 64'h1, 0);
        add_vector("max", MAX, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 64'h1, 0);
        add_vector("maxu", MAXU, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1, 64'hFFFF_FFFF_FFFF_FFFF, 0);
        // Logic
        add_vector("and", AND_OP, 64'h00FF_00FF_00FF_00FF, 64'h0F0F_0F0F_0F0F_0F0F,
                   64'h000F_000F_000F_000F, 0);
        add_vector("xnor", XNOR_OP, 64'h00FF_00FF_00FF_00FF, 64'h0F0F_0F0F_0F0F_0F0F,
                   64'hF00F_F00F_F00F_F00F, 0);
        add_vector("andn", ANDN, 64'h00FF_00FF_00FF_00FF, 64'h0F0F_0F0F_0F0F_0F0F,
                   64'h00F0_00F0_00F0_00F0, 0);
        add_vector("orn", ORN, 64'h00FF_00FF_00FF_00FF, 64'h0F0F_0F0F_0F0F_0F0F,
                   64'hF0FF_F0FF_F0FF_F0FF, 0);
        add_vector("orcb", ORCB, 64'h0001_0000_00FF_0000, 64'h0, 64'h00FF_0000_00FF_0000, 0);
        // Extension and byte reverse
        add_vector("sextb", SEXTB, 64'h0123_4567_89AB_CDEF, 64'h0, 64'hFFFF_FFFF_FFFF_FFEF, 0);
        add_vector("sexth", SEXTH, 64'h0123_4567_89AB_CDEF, 64'h0, 64'hFFFF_FFFF_FFFF_CDEF, 0);
        add_vector("zexth", ZEXTH, 64'h0123_4567_89AB_CDEF, 64'h0, 64'h0000_0000_0000_CDEF, 0);
        add_vector("zextw", ZEXTW, 64'h0123_4567_89AB_CDEF, 64'h0, 64'h0000_0000_89AB_CDEF, 0);
        add_vector("rev8", REV8, 64'h0123_4567_89AB_CDEF, 64'h0, 64'hEFCD_AB89_6745_2301, 0);
        // Back-pressure, req held 10 extra cycles
        add_vector("add_hold", ADD, 64'h1234, 64'h1, 64'h1235, 10);

        // Reset may still be unknown at time zero
        cycles = 0;
        while (arst_n !== 1'b1 && cycles < ack_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            timeout_count++;
        end

        for (int i = 0; i < names.size(); i++) begin
            run_vector(i);
        end

        errors = checker_inst.mismatch_count + checker_inst.protocol_count + timeout_count;
        $display("Errors: %0d mismatches, %0d protocol, %0d timeouts",
                 checker_inst.mismatch_count, checker_inst.protocol_count, timeout_count);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- files.f
source/alu_pkg.sv
source/alu_unit_if.sv
source/alu_add.sv
source/alu_shift.sv
source/alu_cmp.sv
source/alu_logic.sv
source/alu.sv
source/exe_alu_handshake.sv
source/exe_alu_top.sv
sim/tb_clock_gen.sv
sim/tb_exe_alu_checker.sv
sim/tb_exe_alu.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the ALU stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_exe_alu -o tb_exe_alu \
    && ./obj_dir/tb_exe_alu | tee /dev/stderr | grep -q "^Everything OK$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
